// File: common/eth_pkg.sv
// ********************
// shared types for the receive-side router
// byte, MAC and ethertype widths
// frame header and payload beat structs
// broadcast address constant
// ********************

package eth_pkg;

    // one payload byte
    typedef logic [7:0] byte_t;

    // 48-bit station address
    typedef logic [47:0] mac_t;

    // ethertype field of the header
    typedef logic [15:0] ethertype_t;

    // frame header as it sits on the header stream, 112 bits
    typedef struct packed {
        mac_t       dest_mac;
        mac_t       src_mac;
        ethertype_t eth_type;
    } eth_hdr_t;

    // one beat of the payload stream
    // user is the error flag, passed through untouched
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } payload_beat_t;

    // all-ones destination, accepted regardless of local address
    localparam mac_t BROADCAST_MAC = 48'hffff_ffff_ffff;

endpackage

// File: logic/frame_classifier.sv
// ********************
// frame classifier
// programmable ethertype to port rule table
// destination MAC filter with broadcast and promiscuous modes
// combinational select and drop outputs
// ********************

`timescale 1ns/1ps

module frame_classifier #(
    parameter int M_COUNT    = 4,
    parameter int RULE_COUNT = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cfg_wr,
    input  logic [$clog2(RULE_COUNT)-1:0] cfg_index,
    input  eth_pkg::ethertype_t         cfg_type,
    input  logic [$clog2(M_COUNT)-1:0]  cfg_port,
    input  eth_pkg::mac_t               local_mac,
    input  logic                        promisc,
    input  eth_pkg::eth_hdr_t           hdr,
    output logic [$clog2(M_COUNT)-1:0]  select,
    output logic                        drop
);

    import eth_pkg::*;

    localparam int SEL_WIDTH = $clog2(M_COUNT);

    typedef logic [SEL_WIDTH-1:0] port_sel_t;

    // rule table
    logic [RULE_COUNT-1:0] rule_valid;
    ethertype_t            rule_type [RULE_COUNT];
    port_sel_t             rule_port [RULE_COUNT];

    logic found;
    logic mac_ok;

    // only the valid bits need clearing
    always_ff @(posedge clk) begin
        if (rst) begin
            rule_valid <= '0;
        end else if (cfg_wr) begin
            rule_valid[cfg_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            rule_type[cfg_index] <= cfg_type;
            rule_port[cfg_index] <= cfg_port;
        end
    end

    // lowest matching index wins
    always_comb begin
        found  = 1'b0;
        select = '0;
        for (int i = 0; i < RULE_COUNT; i++) begin
            if (!found && rule_valid[i] && (rule_type[i] == hdr.eth_type)) begin
                found  = 1'b1;
                select = rule_port[i];
            end
        end
    end

    // station filter
    assign mac_ok = promisc
                 || (hdr.dest_mac == local_mac)
                 || (hdr.dest_mac == BROADCAST_MAC);

    assign drop = !found || !mac_ok;

endmodule

// File: demux/payload_skid_buffer.sv
// ********************
// payload skid buffer
// output register plus one temp register
// one-hot port valid, shared beat
// ********************

`timescale 1ns/1ps

module payload_skid_buffer #(
    parameter int M_COUNT = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_pkg::payload_beat_t in_beat,
    input  logic [M_COUNT-1:0]     in_valid,
    input  logic [M_COUNT-1:0]     out_ready,
    output logic                   ready_early,
    output eth_pkg::payload_beat_t out_beat,
    output logic [M_COUNT-1:0]     out_valid
);

    import eth_pkg::*;

    logic [M_COUNT-1:0] out_valid_reg, out_valid_next;
    logic [M_COUNT-1:0] temp_valid_reg, temp_valid_next;
    payload_beat_t      out_beat_reg;
    payload_beat_t      temp_beat_reg;

    logic in_any;
    logic out_take;
    logic load_out;
    logic load_temp;
    logic temp_to_out;

    assign in_any   = |in_valid;
    assign out_take = |(out_ready & out_valid_reg);

    assign out_beat  = out_beat_reg;
    assign out_valid = out_valid_reg;

    // safe to accept next cycle: output drains now or nothing is held
    assign ready_early = out_take || ((temp_valid_reg == '0) && (out_valid_reg == '0));

    always_comb begin
        out_valid_next  = out_valid_reg;
        temp_valid_next = temp_valid_reg;
        load_out        = 1'b0;
        load_temp       = 1'b0;
        temp_to_out     = 1'b0;

        if (in_any) begin
            if (out_take || (out_valid_reg == '0)) begin
                out_valid_next = in_valid;
                load_out       = 1'b1;
            end else begin
                temp_valid_next = in_valid;
                load_temp       = 1'b1;
            end
        end else if (out_take) begin
            // temp may be empty, which just clears the output
            out_valid_next  = temp_valid_reg;
            temp_valid_next = '0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg  <= '0;
            temp_valid_reg <= '0;
        end else begin
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_beat_reg <= in_beat;
        end else if (temp_to_out) begin
            out_beat_reg <= temp_beat_reg;
        end
        if (load_temp) begin
            temp_beat_reg <= in_beat;
        end
    end

endmodule

// File: demux/eth_demux.sv
// ********************
// frame demultiplexer
// latches port select and drop at header accept
// steers header to one output port
// payload beats go through the skid buffer
// ********************

`timescale 1ns/1ps

module eth_demux #(
    parameter int M_COUNT = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       enable,
    input  logic [$clog2(M_COUNT)-1:0] select,
    input  logic                       drop,
    input  eth_pkg::eth_hdr_t          s_hdr,
    input  logic                       s_hdr_valid,
    output logic                       s_hdr_ready,
    input  eth_pkg::payload_beat_t     s_payload,
    input  logic                       s_payload_valid,
    output logic                       s_payload_ready,
    output eth_pkg::eth_hdr_t          m_hdr,
    output logic [M_COUNT-1:0]         m_hdr_valid,
    input  logic [M_COUNT-1:0]         m_hdr_ready,
    output eth_pkg::payload_beat_t     m_payload,
    output logic [M_COUNT-1:0]         m_payload_valid,
    input  logic [M_COUNT-1:0]         m_payload_ready,
    output logic                       frame_dropped
);

    import eth_pkg::*;

    localparam int SEL_WIDTH = $clog2(M_COUNT);

    typedef logic [SEL_WIDTH-1:0] port_sel_t;
    typedef logic [M_COUNT-1:0]   port_mask_t;

    logic       frame_reg, frame_next;
    port_sel_t  select_reg, select_next;
    logic       drop_reg, drop_next;
    logic       hdr_ready_reg, hdr_ready_next;
    logic       payload_ready_reg, payload_ready_next;
    port_mask_t hdr_valid_reg, hdr_valid_next;
    eth_hdr_t   hdr_reg;

    logic       hdr_accept;
    logic       payload_accept;
    port_mask_t beat_mask;
    logic       skid_ready_early;

    // enable cuts both ready outputs in the same cycle
    assign s_hdr_ready     = hdr_ready_reg && enable;
    assign s_payload_ready = payload_ready_reg && enable;

    assign hdr_accept     = s_hdr_valid && s_hdr_ready;
    assign payload_accept = s_payload_valid && s_payload_ready;
    assign frame_dropped  = hdr_accept && drop;

    assign m_hdr       = hdr_reg;
    assign m_hdr_valid = hdr_valid_reg;

    // zero mask discards the beat
    assign beat_mask = (payload_accept && !drop_reg) ? port_mask_t'(1) << select_reg : '0;

    always_comb begin
        frame_next     = frame_reg;
        select_next    = select_reg;
        drop_next      = drop_reg;
        hdr_valid_next = hdr_valid_reg & ~m_hdr_ready;

        // end of frame
        if (payload_accept && s_payload.last) begin
            frame_next = 1'b0;
            drop_next  = 1'b0;
        end

        // start of frame, route is fixed from here to the last beat
        if (hdr_accept) begin
            frame_next  = 1'b1;
            select_next = select;
            drop_next   = drop;
            if (!drop) begin
                hdr_valid_next = port_mask_t'(1) << select;
            end
        end

        hdr_ready_next     = !frame_next && (hdr_valid_next == '0);
        payload_ready_next = frame_next && (skid_ready_early || drop_next);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_reg         <= 1'b0;
            select_reg        <= '0;
            drop_reg          <= 1'b0;
            hdr_ready_reg     <= 1'b0;
            payload_ready_reg <= 1'b0;
            hdr_valid_reg     <= '0;
        end else begin
            frame_reg         <= frame_next;
            select_reg        <= select_next;
            drop_reg          <= drop_next;
            hdr_ready_reg     <= hdr_ready_next;
            payload_ready_reg <= payload_ready_next;
            hdr_valid_reg     <= hdr_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            hdr_reg <= s_hdr;
        end
    end

    payload_skid_buffer #(
        .M_COUNT(M_COUNT)
    ) u_skid (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (s_payload),
        .in_valid    (beat_mask),
        .out_ready   (m_payload_ready),
        .ready_early (skid_ready_early),
        .out_beat    (m_payload),
        .out_valid   (m_payload_valid)
    );

endmodule

// File: logic/route_counters.sv
// ********************
// per-port delivered-frame counters
// dropped-frame counter
// saturating at all ones
// ********************

`timescale 1ns/1ps

module route_counters #(
    parameter int M_COUNT   = 4,
    parameter int CNT_WIDTH = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [M_COUNT-1:0]                hdr_valid,
    input  logic [M_COUNT-1:0]                hdr_ready,
    input  logic                              frame_dropped,
    output logic [M_COUNT-1:0][CNT_WIDTH-1:0] port_frames,
    output logic [CNT_WIDTH-1:0]              drop_frames
);

    typedef logic [CNT_WIDTH-1:0] count_t;

    localparam count_t COUNT_MAX = '1;

    // one header handshake per delivered frame
    logic [M_COUNT-1:0] delivered;

    assign delivered = hdr_valid & hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            port_frames <= '0;
            drop_frames <= '0;
        end else begin
            for (int i = 0; i < M_COUNT; i++) begin
                if (delivered[i] && (port_frames[i] != COUNT_MAX)) begin
                    port_frames[i] <= port_frames[i] + 1'b1;
                end
            end
            if (frame_dropped && (drop_frames != COUNT_MAX)) begin
                drop_frames <= drop_frames + 1'b1;
            end
        end
    end

endmodule

// File: logic/eth_router_top.sv
// ********************
// receive-side router top level
// classifier, demultiplexer and counters
// ********************

`timescale 1ns/1ps

module eth_router_top #(
    parameter int M_COUNT    = 4,
    parameter int RULE_COUNT = 4,
    parameter int CNT_WIDTH  = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    // input frame
    input  eth_pkg::eth_hdr_t                 s_hdr,
    input  logic                              s_hdr_valid,
    output logic                              s_hdr_ready,
    input  eth_pkg::payload_beat_t            s_payload,
    input  logic                              s_payload_valid,
    output logic                              s_payload_ready,
    // output ports, shared header and beat
    output eth_pkg::eth_hdr_t                 m_hdr,
    output logic [M_COUNT-1:0]                m_hdr_valid,
    input  logic [M_COUNT-1:0]                m_hdr_ready,
    output eth_pkg::payload_beat_t            m_payload,
    output logic [M_COUNT-1:0]                m_payload_valid,
    input  logic [M_COUNT-1:0]                m_payload_ready,
    // rule table and filter setup
    input  logic                              cfg_wr,
    input  logic [$clog2(RULE_COUNT)-1:0]     cfg_index,
    input  eth_pkg::ethertype_t               cfg_type,
    input  logic [$clog2(M_COUNT)-1:0]        cfg_port,
    input  eth_pkg::mac_t                     local_mac,
    input  logic                              promisc,
    input  logic                              enable,
    // status
    output logic [M_COUNT-1:0][CNT_WIDTH-1:0] port_frames,
    output logic [CNT_WIDTH-1:0]              drop_frames
);

    logic [$clog2(M_COUNT)-1:0] select;
    logic                       drop;
    logic                       frame_dropped;

    frame_classifier #(
        .M_COUNT    (M_COUNT),
        .RULE_COUNT (RULE_COUNT)
    ) u_classifier (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_index (cfg_index),
        .cfg_type  (cfg_type),
        .cfg_port  (cfg_port),
        .local_mac (local_mac),
        .promisc   (promisc),
        .hdr       (s_hdr),
        .select    (select),
        .drop      (drop)
    );

    eth_demux #(
        .M_COUNT(M_COUNT)
    ) u_demux (
        .clk             (clk),
        .rst             (rst),
        .enable          (enable),
        .select          (select),
        .drop            (drop),
        .s_hdr           (s_hdr),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_hdr           (m_hdr),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .frame_dropped   (frame_dropped)
    );

    route_counters #(
        .M_COUNT   (M_COUNT),
        .CNT_WIDTH (CNT_WIDTH)
    ) u_counters (
        .clk           (clk),
        .rst           (rst),
        .hdr_valid     (m_hdr_valid),
        .hdr_ready     (m_hdr_ready),
        .frame_dropped (frame_dropped),
        .port_frames   (port_frames),
        .drop_frames   (drop_frames)
    );

endmodule

// File: sim/tb_eth_router.sv
// ********************
// testbench for the receive-side router
// rule model, per-port scoreboard queues
// protocol assertions, random back-pressure
// timeout by cycle count
// ********************

`timescale 1ns/1ps

module tb_eth_router;

    import eth_pkg::*;

    localparam int M_COUNT     = 4;
    localparam int RULE_COUNT  = 4;
    localparam int CNT_WIDTH   = 16;
    localparam int MAX_LEN     = 12;
    localparam int FRAME_TOTAL = 50;
    // up to MAX_LEN + 1 transfers per frame at 30 cycles each under random ready
    localparam int CYCLE_LIMIT = FRAME_TOTAL * (MAX_LEN + 1) * 30;
    localparam mac_t LOCAL_MAC = 48'h0200_5e10_2030;

    logic                              clk = 1'b0;
    logic                              rst;
    eth_hdr_t                          s_hdr;
    logic                              s_hdr_valid;
    logic                              s_hdr_ready;
    payload_beat_t                     s_payload;
    logic                              s_payload_valid;
    logic                              s_payload_ready;
    eth_hdr_t                          m_hdr;
    logic [M_COUNT-1:0]                m_hdr_valid;
    logic [M_COUNT-1:0]                m_hdr_ready = '1;
    payload_beat_t                     m_payload;
    logic [M_COUNT-1:0]                m_payload_valid;
    logic [M_COUNT-1:0]                m_payload_ready = '1;
    logic                              cfg_wr;
    logic [$clog2(RULE_COUNT)-1:0]     cfg_index;
    ethertype_t                        cfg_type;
    logic [$clog2(M_COUNT)-1:0]        cfg_port;
    mac_t                              local_mac;
    logic                              promisc;
    logic                              enable;
    logic [M_COUNT-1:0][CNT_WIDTH-1:0] port_frames;
    logic [CNT_WIDTH-1:0]              drop_frames;

    // reference model of the rule table
    ethertype_t    rule_type [RULE_COUNT];
    int            rule_port [RULE_COUNT];
    eth_hdr_t      hdr_q [M_COUNT][$];
    payload_beat_t beat_q [M_COUNT][$];
    int            sent_frames [M_COUNT];
    int            dropped;

    logic [31:0] rng_data  = 32'h175a;
    logic [31:0] rng_ready = 32'h175a;
    logic        bp_on = 1'b0;
    logic        rst_q = 1'b0;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    eth_router_top #(
        .M_COUNT    (M_COUNT),
        .RULE_COUNT (RULE_COUNT),
        .CNT_WIDTH  (CNT_WIDTH)
    ) DUT (
        .clk             (clk),
        .rst             (rst),
        .s_hdr           (s_hdr),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_hdr           (m_hdr),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .cfg_wr          (cfg_wr),
        .cfg_index       (cfg_index),
        .cfg_type        (cfg_type),
        .cfg_port        (cfg_port),
        .local_mac       (local_mac),
        .promisc         (promisc),
        .enable          (enable),
        .port_frames     (port_frames),
        .drop_frames     (drop_frames)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        rst_q <= rst;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic value_mismatch(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic protocol_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %-14s done, %0d errors so far", name, errors);
    endtask

    // port from the lowest matching rule or -1 for a dropped frame
    function automatic int expected_port(input eth_hdr_t h);
        logic mac_ok;
        mac_ok = promisc || (h.dest_mac == LOCAL_MAC) || (h.dest_mac == BROADCAST_MAC);
        if (!mac_ok) begin
            return -1;
        end
        for (int i = 0; i < RULE_COUNT; i++) begin
            if (rule_type[i] == h.eth_type) begin
                return rule_port[i];
            end
        end
        return -1;
    endfunction

    // mac_kind 0 gives local, 1 broadcast and anything else a foreign address
    // type_sel past the table gives an unmatched ethertype
    function automatic eth_hdr_t make_hdr(input int mac_kind, input int type_sel);
        eth_hdr_t h;
        rng_data = xorshift(rng_data);
        h.src_mac = {rng_data[15:0], rng_data};
        case (mac_kind)
            0:       h.dest_mac = LOCAL_MAC;
            1:       h.dest_mac = BROADCAST_MAC;
            default: h.dest_mac = {16'h0a0b, rng_data};
        endcase
        h.eth_type = (type_sel < RULE_COUNT) ? rule_type[type_sel] : 16'h9000;
        return h;
    endfunction

    task automatic program_rules();
        ethertype_t types [RULE_COUNT];
        int         ports [RULE_COUNT];
        types = '{16'h0800, 16'h86dd, 16'h0806, 16'h88cc};
        ports = '{2, 0, 3, 1};
        for (int i = 0; i < RULE_COUNT; i++) begin
            @(negedge clk);
            cfg_wr       = 1'b1;
            cfg_index    = i[$clog2(RULE_COUNT)-1:0];
            cfg_type     = types[i];
            cfg_port     = ports[i][$clog2(M_COUNT)-1:0];
            rule_type[i] = types[i];
            rule_port[i] = ports[i];
        end
        @(negedge clk);
        cfg_wr = 1'b0;
    endtask

    // len 0 picks a random length
    // stall_at holds enable low for a few cycles at that beat
    task automatic send_frame(input eth_hdr_t h, input int len, input int stall_at);
        payload_beat_t beats [MAX_LEN];
        int            port;
        int            n;
        n = len;
        if (n <= 0) begin
            rng_data = xorshift(rng_data);
            n = 1 + int'(rng_data % 32'(MAX_LEN));
        end
        for (int i = 0; i < n; i++) begin
            rng_data = xorshift(rng_data);
            beats[i].data = rng_data[7:0];
            beats[i].user = rng_data[8];
            beats[i].last = (i == n - 1);
        end
        port = expected_port(h);
        if (port >= 0) begin
            hdr_q[port].push_back(h);
            for (int i = 0; i < n; i++) begin
                beat_q[port].push_back(beats[i]);
            end
            sent_frames[port]++;
        end else begin
            dropped++;
        end

        @(negedge clk);
        s_hdr       = h;
        s_hdr_valid = 1'b1;
        while (!s_hdr_ready) @(negedge clk);
        @(posedge clk);
        @(negedge clk);
        s_hdr_valid = 1'b0;

        for (int i = 0; i < n; i++) begin
            s_payload       = beats[i];
            s_payload_valid = 1'b1;
            if (i == stall_at) begin
                enable = 1'b0;
                repeat (4) @(negedge clk);
                // valid off for the cycle where enable comes back
                s_payload_valid = 1'b0;
                enable          = 1'b1;
                @(negedge clk);
                s_payload_valid = 1'b1;
            end
            while (!s_payload_ready) @(negedge clk);
            @(posedge clk);
            @(negedge clk);
        end
        s_payload_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int pending;
        do begin
            @(negedge clk);
            pending = 0;
            for (int p = 0; p < M_COUNT; p++) begin
                pending += hdr_q[p].size() + beat_q[p].size();
            end
        end while (pending != 0);
        repeat (3) @(negedge clk);
    endtask

    task automatic check_counters();
        for (int p = 0; p < M_COUNT; p++) begin
            checks++;
            assert (port_frames[p] == CNT_WIDTH'(sent_frames[p]))
                else value_mismatch($sformatf("port %0d count %0d, expected %0d",
                                              p, port_frames[p], sent_frames[p]));
        end
        checks++;
        assert (drop_frames == CNT_WIDTH'(dropped))
            else value_mismatch($sformatf("drop count %0d, expected %0d", drop_frames, dropped));
    endtask

    // random output ready while back-pressure is on
    always @(negedge clk) begin
        if (bp_on) begin
            rng_ready       = xorshift(rng_ready);
            m_payload_ready = rng_ready[3:0];
            m_hdr_ready     = rng_ready[7:4];
        end else begin
            m_payload_ready = '1;
            m_hdr_ready     = '1;
        end
    end

    // scoreboard compares every output handshake with the queued frame
    always @(posedge clk) begin
        eth_hdr_t      exp_h;
        payload_beat_t exp_b;
        if (!rst) begin
            for (int p = 0; p < M_COUNT; p++) begin
                if (m_hdr_valid[p] && m_hdr_ready[p]) begin
                    checks++;
                    if (hdr_q[p].size() == 0) begin
                        protocol_error($sformatf("header on port %0d with no frame due", p));
                    end else begin
                        exp_h = hdr_q[p].pop_front();
                        assert (m_hdr == exp_h)
                            else value_mismatch($sformatf("port %0d header %h, expected %h",
                                                          p, m_hdr, exp_h));
                    end
                end
                if (m_payload_valid[p] && m_payload_ready[p]) begin
                    checks++;
                    if (beat_q[p].size() == 0) begin
                        protocol_error($sformatf("payload beat on port %0d with none due", p));
                    end else begin
                        exp_b = beat_q[p].pop_front();
                        assert (m_payload == exp_b)
                            else value_mismatch($sformatf("port %0d beat %h, expected %h",
                                                          p, m_payload, exp_b));
                    end
                end
            end
        end
    end

    reset_idle: assert property (@(posedge clk) rst_q |-> (m_hdr_valid == '0
            && m_payload_valid == '0 && !s_hdr_ready && !s_payload_ready
            && port_frames == '0 && drop_frames == '0))
        else value_mismatch("outputs not idle or counters not zero around reset");

    single_port: assert property (@(posedge clk) disable iff (rst)
            $onehot0(m_hdr_valid) && $onehot0(m_payload_valid))
        else value_mismatch("more than one port valid bit high");

    enable_gate: assert property (@(posedge clk) !enable |-> (!s_hdr_ready && !s_payload_ready))
        else value_mismatch("input ready high while enable is low");

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles with frames still pending", cycles);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        eth_hdr_t h;
        rst             = 1'b1;
        s_hdr           = '0;
        s_hdr_valid     = 1'b0;
        s_payload       = '0;
        s_payload_valid = 1'b0;
        cfg_wr          = 1'b0;
        cfg_index       = '0;
        cfg_type        = '0;
        cfg_port        = '0;
        local_mac       = LOCAL_MAC;
        promisc         = 1'b0;
        enable          = 1'b1;
        dropped         = 0;
        for (int p = 0; p < M_COUNT; p++) begin
            sent_frames[p] = 0;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        finish_test("reset");

        program_rules();
        for (int t = 0; t < RULE_COUNT; t++) begin
            send_frame(make_hdr(0, t), 0, -1);
            send_frame(make_hdr(1, t), 0, -1);
        end
        promisc = 1'b1;
        for (int t = 0; t < RULE_COUNT; t++) begin
            send_frame(make_hdr(2, t), 0, -1);
        end
        promisc = 1'b0;
        wait_drain();
        finish_test("rule routing");

        // unmatched type, foreign address, then a good frame
        repeat (2) begin
            send_frame(make_hdr(0, RULE_COUNT), 0, -1);
            send_frame(make_hdr(2, 1), 0, -1);
            send_frame(make_hdr(1, 2), 0, -1);
        end
        wait_drain();
        finish_test("drop");

        bp_on = 1'b1;
        for (int n = 0; n < 30; n++) begin
            rng_data = xorshift(rng_data);
            send_frame(make_hdr(int'(rng_data[3:0]) % 3, int'(rng_data[7:4]) % 5), 0, -1);
        end
        wait_drain();
        bp_on = 1'b0;
        finish_test("back-pressure");

        // header held while enable is low, then a stall inside the payload
        h = make_hdr(0, 0);
        @(negedge clk);
        enable = 1'b0;
        @(negedge clk);
        s_hdr       = h;
        s_hdr_valid = 1'b1;
        repeat (20) @(negedge clk);
        s_hdr_valid = 1'b0;
        enable      = 1'b1;
        send_frame(h, 8, 3);
        wait_drain();
        finish_test("enable");

        check_counters();
        finish_test("counters");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: src.f
common/eth_pkg.sv
logic/frame_classifier.sv
demux/payload_skid_buffer.sv
demux/eth_demux.sv
logic/route_counters.sv
logic/eth_router_top.sv
sim/tb_eth_router.sv

// File: run_sim.sh
#!/bin/sh
# build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_eth_router \
    -Mdir obj_dir -o tb_eth_router

./obj_dir/tb_eth_router | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
